// File: tb.f
logic/pll_pkg.sv
logic/pll_cfg_decode.sv
logic/pll_lock_monitor.sv
logic/pll_out_divider.sv
logic/pll_status.sv
logic/pll_ctrl_top.sv
sim/pll_ctrl_asserts.sv
sim/tb_pll_ctrl.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_pll_ctrl -f tb.f
	./obj_dir/Vtb_pll_ctrl +verilator+error+limit+100

clean:
	rm -rf obj_dir

// File: sim/tb_pll_ctrl.sv
/*
 * testbench for the pll control top level
 *  clock, reset, watchdog, fb and vco pulse sources,
 *  register model, lock / loss / output tick checks
 */
`timescale 1ns/10ps
`default_nettype none

module tb_pll_ctrl;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 10;
    localparam int MAX_DIVIN  = 4;          // keeps lock windows short
    localparam int WIN_MAX    = pll_pkg::LOCK_WINDOW * MAX_DIVIN;
    localparam int VCO_PULSES = 48;
    localparam int BYP_CYCLES = 60;
    // summed test lengths, doubled for margin
    localparam int RUN_CYCLES = 2 * (RST_CYCLES + 250 + 10 * WIN_MAX
                              + 4 * VCO_PULSES + 2 * BYP_CYCLES);

    logic                        clkin;
    logic                        rst_n;
    logic                        wr_en;
    logic [pll_pkg::ADDRW-1:0]   addr;
    logic [pll_pkg::DATAW-1:0]   wdata;
    logic                        rd_en;
    logic [pll_pkg::ADDRW-1:0]   rd_addr;
    logic                        fb_tick;
    logic                        vco_tick;
    pll_pkg::pll_cfg_t           cfg;
    logic [pll_pkg::NOUT-1:0]    clkout_tick;
    logic                        freqlock;
    pll_pkg::pll_stat_t          stat;
    logic                        rd_valid;
    logic [pll_pkg::DATAW-1:0]   rdata;

    // register model
    logic        m_en = 1'b0;
    logic        m_bypass = 1'b0;
    logic [7:0]  m_divin = 8'd1;
    logic [15:0] m_divfb = 16'd1;
    logic [3:0]  m_clken = 4'd0;
    logic [7:0]  m_divout [pll_pkg::NOUT];
    logic        m_lock = 1'b0;
    logic        m_lost = 1'b0;
    logic        m_err = 1'b0;

    int fb_div = 1;                 // clkin cycles per fb tick
    int fb_per_win = 0;             // fb ticks per LOCK_WINDOW*fb_div cycles
    int tick_total [pll_pkg::NOUT];
    int tick_start [pll_pkg::NOUT];
    int win_cycles;
    int n;

    pll_ctrl_top u_dut (.*);

    initial begin
        clkin = 1'b0;
        forever #(CLK_PERIOD / 2) clkin = ~clkin;
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // fb source, evenly spaced, first fb_per_win slots of each window
    initial begin : fb_source
        int phase;
        phase = 0;
        fb_tick = 1'b0;
        forever begin
            @(posedge clkin);
            fb_tick <= (phase % fb_div == 0) && (phase / fb_div < fb_per_win);
            phase = (phase + 1) % (pll_pkg::LOCK_WINDOW * fb_div);
        end
    end

    // output tick counters, sampled mid-cycle
    initial begin
        for (int i = 0; i < pll_pkg::NOUT; i++) begin
            tick_total[i] = 0;
        end
        forever begin
            @(negedge clkin);
            assert (u_dut.u_asserts.fail_cnt == 0)
                else report_problem("a bound concurrent assertion failed");
            for (int i = 0; i < pll_pkg::NOUT; i++) begin
                if (clkout_tick[i]) tick_total[i]++;
            end
        end
    end

    // ============================================================
    // helpers
    // ============================================================
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("TESTS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
        @(posedge clkin);
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clkin);           // DUT takes the write here
        wr_en <= 1'b0;
    endtask

    // expected read data in write layout
    function automatic logic [31:0] model_read(input logic [3:0] a);
        logic [31:0] v;
        int          k;
        v = '0;
        k = int'(a) - int'(pll_pkg::ADDR_DIVOUT0);
        case (a)
            pll_pkg::ADDR_CTRL:   v[1:0]  = {m_bypass, m_en};
            pll_pkg::ADDR_DIV:    v[23:0] = {m_divfb, m_divin};
            pll_pkg::ADDR_CLKEN:  v[3:0]  = m_clken;
            pll_pkg::ADDR_STATUS: v[2:0]  = {m_lock, m_lost, m_err};
            default: begin
                if (k >= 0 && k < pll_pkg::NOUT) begin
                    v[7:0] = m_divout[k];
                end
            end
        endcase
        return v;
    endfunction

    // cfg port towards the analog macro vs register model
    task automatic check_cfg();
        assert (cfg.en === m_en) else report_mismatch("cfg.en", cfg.en, m_en);
        assert (cfg.bypass === m_bypass)
            else report_mismatch("cfg.bypass", cfg.bypass, m_bypass);
        assert (cfg.divin === m_divin)
            else report_mismatch("cfg.divin", cfg.divin, m_divin);
        assert (cfg.divfb === m_divfb)
            else report_mismatch("cfg.divfb", cfg.divfb, m_divfb);
        assert (cfg.clken === m_clken)
            else report_mismatch("cfg.clken", cfg.clken, m_clken);
        for (int i = 0; i < pll_pkg::NOUT; i++) begin
            assert (cfg.divout[i] === m_divout[i])
                else report_mismatch($sformatf("cfg.divout[%0d]", i),
                                     cfg.divout[i], m_divout[i]);
        end
    endtask

    task automatic reg_check(input logic [3:0] a);
        logic [31:0] exp;
        exp = model_read(a);
        @(posedge clkin);
        rd_en   <= 1'b1;
        rd_addr <= a;
        @(posedge clkin);
        rd_en <= 1'b0;
        @(negedge clkin);
        assert (rd_valid === 1'b1) else report_problem("rd_valid missing after rd_en");
        assert (rdata === exp) else report_mismatch($sformatf("rdata @%0d", a), rdata, exp);
        check_cfg();
        @(negedge clkin);
        assert (rd_valid === 1'b0) else report_problem("rd_valid high for two cycles");
    endtask

    task automatic mark_ticks();
        for (int i = 0; i < pll_pkg::NOUT; i++) begin
            tick_start[i] = tick_total[i];
        end
    endtask

    // one tick per divout source pulses on enabled outputs only
    task automatic check_tick_counts(input int pulses);
        int got;
        int exp;
        for (int i = 0; i < pll_pkg::NOUT; i++) begin
            got = tick_total[i] - tick_start[i];
            exp = (m_en && m_clken[i]) ? pulses / int'(m_divout[i]) : 0;
            assert (got == exp)
                else report_mismatch($sformatf("count of clkout_tick[%0d]", i), got, exp);
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        addr     = '0;
        wdata    = '0;
        rd_en    = 1'b0;
        rd_addr  = '0;
        vco_tick = 1'b0;
        void'($urandom(32'hdfc023e3));
        for (int i = 0; i < pll_pkg::NOUT; i++) begin
            m_divout[i] = 8'd1;
        end
        repeat (RST_CYCLES) @(posedge clkin);
        rst_n <= 1'b1;
        @(negedge clkin);
        assert (freqlock === 1'b0) else report_mismatch("freqlock", freqlock, 0);
        assert (clkout_tick === '0) else report_mismatch("clkout_tick", clkout_tick, 0);
        assert (32'(stat) === 0) else report_mismatch("stat", 32'(stat), 0);

        // register read-back, whole map incl. unmapped words
        for (int pass = 0; pass < 2; pass++) begin
            m_en     = 1'($urandom);
            m_bypass = 1'($urandom);
            reg_write(pll_pkg::ADDR_CTRL, {30'd0, m_bypass, m_en});
            m_divin = 8'($urandom_range(255, 1));
            m_divfb = 16'($urandom_range(65535, 1));
            reg_write(pll_pkg::ADDR_DIV, {8'd0, m_divfb, m_divin});
            m_clken = 4'($urandom);
            reg_write(pll_pkg::ADDR_CLKEN, {28'd0, m_clken});
            for (int i = 0; i < pll_pkg::NOUT; i++) begin
                m_divout[i] = 8'($urandom_range(255, 1));
                reg_write(4'(pll_pkg::ADDR_DIVOUT0 + i), {24'd0, m_divout[i]});
            end
            for (int a = 0; a < 16; a++) begin
                reg_check(4'(a));
            end
        end

        // zero divin, then zero divfb, both refused and flagged
        for (int z = 0; z < 2; z++) begin
            reg_write(pll_pkg::ADDR_DIV, (z == 0) ? {8'd0, m_divfb, 8'd0}
                                                  : {8'd0, 16'd0, m_divin});
            m_err = 1'b1;
            reg_check(pll_pkg::ADDR_DIV);
            reg_check(pll_pkg::ADDR_STATUS);
            reg_write(pll_pkg::ADDR_STATUS, 32'h1);     // w1c cfg_err
            m_err = 1'b0;
            reg_check(pll_pkg::ADDR_STATUS);
        end

        // set up outputs while disabled, since any write restarts lock
        m_en     = 1'b0;
        m_bypass = 1'b0;
        reg_write(pll_pkg::ADDR_CTRL, 32'd0);
        m_clken = 4'($urandom_range(14, 1));
        reg_write(pll_pkg::ADDR_CLKEN, {28'd0, m_clken});
        for (int i = 0; i < pll_pkg::NOUT; i++) begin
            m_divout[i] = 8'($urandom_range(5, 1));
            reg_write(4'(pll_pkg::ADDR_DIVOUT0 + i), {24'd0, m_divout[i]});
        end
        m_divin = 8'($urandom_range(MAX_DIVIN, 1));
        reg_write(pll_pkg::ADDR_DIV, {8'd0, m_divfb, m_divin});
        win_cycles = pll_pkg::LOCK_WINDOW * int'(m_divin);
        fb_div     = int'(m_divin);
        fb_per_win = pll_pkg::LOCK_WINDOW;

        // lock after the cfg_chg cycle plus LOCK_COUNT windows
        reg_write(pll_pkg::ADDR_CTRL, 32'h1);
        m_en = 1'b1;
        repeat (pll_pkg::LOCK_COUNT * win_cycles) @(posedge clkin);
        @(negedge clkin);
        assert (freqlock === 1'b0) else report_mismatch("freqlock early", freqlock, 0);
        @(posedge clkin);
        @(negedge clkin);
        assert (freqlock === 1'b1) else report_mismatch("freqlock", freqlock, 1);
        m_lock = 1'b1;

        // locked, vco pulses with random gaps
        mark_ticks();
        for (int p = 0; p < VCO_PULSES; p++) begin
            @(posedge clkin);
            vco_tick <= 1'b1;
            @(posedge clkin);
            vco_tick <= 1'b0;
            repeat ($urandom_range(2, 0)) @(posedge clkin);
        end
        @(negedge clkin);
        check_tick_counts(VCO_PULSES);
        assert (freqlock === 1'b1) else report_mismatch("freqlock", freqlock, 1);

        // fb stops, lock drops at a window end
        fb_per_win = 0;
        n = 0;
        do begin
            @(negedge clkin);
            n++;
        end while (freqlock === 1'b1 && n < 2 * win_cycles + 2);
        assert (freqlock === 1'b0) else report_problem("freqlock held without fb_tick");
        @(negedge clkin);
        assert (stat.lock_lost === 1'b1)
            else report_mismatch("stat.lock_lost", stat.lock_lost, 1);
        m_lock = 1'b0;
        m_lost = 1'b1;
        reg_check(pll_pkg::ADDR_STATUS);
        reg_write(pll_pkg::ADDR_STATUS, 32'h2);
        m_lost = 1'b0;
        reg_check(pll_pkg::ADDR_STATUS);

        // two ticks short per window never locks
        fb_per_win = pll_pkg::LOCK_WINDOW - 2;
        reg_write(pll_pkg::ADDR_CTRL, 32'h1);
        repeat (5 * win_cycles) begin
            @(negedge clkin);
            assert (freqlock === 1'b0) else report_mismatch("freqlock", freqlock, 0);
        end

        // bypass ticks every divout cycles without lock
        m_bypass = 1'b1;
        reg_write(pll_pkg::ADDR_CTRL, 32'h3);
        @(posedge clkin);           // counters clear on cfg_chg
        mark_ticks();
        repeat (BYP_CYCLES) @(negedge clkin);
        @(posedge clkin);           // last falling-edge count settled
        check_tick_counts(BYP_CYCLES);

        // en low, nothing ticks
        m_en = 1'b0;
        reg_write(pll_pkg::ADDR_CTRL, 32'h2);
        mark_ticks();
        repeat (BYP_CYCLES) @(negedge clkin);
        @(posedge clkin);
        check_tick_counts(BYP_CYCLES);

        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_problem("a bound concurrent assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: sim/pll_ctrl_asserts.sv
/*
 * concurrent checks bound to pll_ctrl_top
 *  read strobe timing, output tick gating, legal dividers
 */
`timescale 1ns/10ps
`default_nettype none

module pll_ctrl_asserts (
    input logic                         clkin,
    input logic                         rst_n,
    input logic                         rd_en,
    input logic                         rd_valid,
    input pll_pkg::pll_cfg_t            cfg,
    input logic                         freqlock,
    input logic [pll_pkg::NOUT-1:0]     clkout_tick
);

    int unsigned fail_cnt = 0;      // failures so far

    // read data answers exactly one cycle after the strobe
    a_rd_valid: assert property (@(posedge clkin) disable iff (!rst_n)
        rd_valid == $past(rd_en))
        else begin
            fail_cnt++;
            $error("rd_valid does not follow rd_en by one cycle");
        end

    a_no_tick_disabled: assert property (@(posedge clkin) disable iff (!rst_n)
        !(!cfg.en && clkout_tick != '0))
        else begin
            fail_cnt++;
            $error("clkout_tick while en is low");
        end

    // outputs need lock unless the reference is passed through
    a_no_tick_unlocked: assert property (@(posedge clkin) disable iff (!rst_n)
        !(!freqlock && !cfg.bypass && clkout_tick != '0))
        else begin
            fail_cnt++;
            $error("clkout_tick without freqlock or bypass");
        end

    a_div_legal: assert property (@(posedge clkin) disable iff (!rst_n)
        cfg.divin != '0 && cfg.divfb != '0)
        else begin
            fail_cnt++;
            $error("zero divin or divfb reached the macro");
        end

endmodule

bind pll_ctrl_top pll_ctrl_asserts u_asserts (
    .clkin       (clkin),
    .rst_n       (rst_n),
    .rd_en       (rd_en),
    .rd_valid    (rd_valid),
    .cfg         (cfg),
    .freqlock    (freqlock),
    .clkout_tick (clkout_tick)
);

`default_nettype wire

// File: logic/pll_ctrl_top.sv
/*
 * pll control top level
 *  write decode, lock monitor, output dividers, status
 */
`timescale 1ns/10ps
`default_nettype none

module pll_ctrl_top (
    input  logic                          clkin,        // reference clock
    input  logic                          rst_n,
    // register write port
    input  logic                          wr_en,
    input  logic [pll_pkg::ADDRW-1:0]     addr,
    input  logic [pll_pkg::DATAW-1:0]     wdata,
    // register read port
    input  logic                          rd_en,
    input  logic [pll_pkg::ADDRW-1:0]     rd_addr,
    // pulses from the analog macro
    input  logic                          fb_tick,
    input  logic                          vco_tick,
    // outputs
    output pll_pkg::pll_cfg_t             cfg,          // to the analog macro
    output logic [pll_pkg::NOUT-1:0]      clkout_tick,
    output logic                          freqlock,
    output pll_pkg::pll_stat_t            stat,
    output logic                          rd_valid,
    output logic [pll_pkg::DATAW-1:0]     rdata
);

    logic       cfg_chg;
    logic       err_pulse;
    logic       lost_pulse;
    logic [2:0] clr_mask;

    pll_cfg_decode u_decode (
        .clkin     (clkin),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .addr      (addr),
        .wdata     (wdata),
        .cfg       (cfg),
        .cfg_chg   (cfg_chg),
        .err_pulse (err_pulse),
        .clr_mask  (clr_mask)
    );

    pll_lock_monitor u_lock (
        .clkin      (clkin),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .cfg_chg    (cfg_chg),
        .fb_tick    (fb_tick),
        .freqlock   (freqlock),
        .lost_pulse (lost_pulse)
    );

    pll_out_divider u_div (
        .clkin       (clkin),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .cfg_chg     (cfg_chg),
        .freqlock    (freqlock),
        .vco_tick    (vco_tick),
        .clkout_tick (clkout_tick)
    );

    pll_status u_status (
        .clkin      (clkin),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .freqlock   (freqlock),
        .lost_pulse (lost_pulse),
        .err_pulse  (err_pulse),
        .clr_mask   (clr_mask),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .stat       (stat),
        .rd_valid   (rd_valid),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: logic/pll_status.sv
/*
 * status and read-back
 *  sticky lock_lost / cfg_err, status word,
 *  registered read mux answering one cycle after rd_en
 */
`timescale 1ns/10ps
`default_nettype none

module pll_status (
    input  logic                          clkin,
    input  logic                          rst_n,
    input  pll_pkg::pll_cfg_t             cfg,
    input  logic                          freqlock,
    input  logic                          lost_pulse,
    input  logic                          err_pulse,
    input  logic [2:0]                    clr_mask,
    input  logic                          rd_en,
    input  logic [pll_pkg::ADDRW-1:0]     rd_addr,
    output pll_pkg::pll_stat_t            stat,
    output logic                          rd_valid,
    output logic [pll_pkg::DATAW-1:0]     rdata
);

    logic                      lock_lost_q;
    logic                      cfg_err_q;
    logic [pll_pkg::DATAW-1:0] rd_mux;

    always_comb begin
        stat.freqlock  = freqlock;      // live, not sticky
        stat.lock_lost = lock_lost_q;
        stat.cfg_err   = cfg_err_q;
    end

    // ============================================================
    // sticky flags, set beats clear
    // ============================================================
    always_ff @(posedge clkin or negedge rst_n) begin
        if (!rst_n) begin
            lock_lost_q <= 1'b0;
            cfg_err_q   <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            lock_lost_q <= lost_pulse | (lock_lost_q & ~clr_mask[pll_pkg::STAT_LOST]);
            cfg_err_q   <= err_pulse  | (cfg_err_q   & ~clr_mask[pll_pkg::STAT_ERR]);
            rd_valid    <= rd_en;       // exactly one cycle later
        end
    end

    // read mux, fields in write layout
    always_comb begin
        rd_mux = '0;
        case (rd_addr)
            pll_pkg::ADDR_CTRL:   rd_mux[1:0] = {cfg.bypass, cfg.en};
            pll_pkg::ADDR_DIV:    rd_mux[pll_pkg::DIVINW+pll_pkg::DIVFBW-1:0] =
                                      {cfg.divfb, cfg.divin};
            pll_pkg::ADDR_CLKEN:  rd_mux[pll_pkg::NOUT-1:0] = cfg.clken;
            pll_pkg::ADDR_STATUS: rd_mux[2:0] = stat;
            default: begin
                if (pll_pkg::is_divout(rd_addr)) begin
                    rd_mux[pll_pkg::DIVOUTW-1:0] = cfg.divout[pll_pkg::divout_idx(rd_addr)];
                end
                // unmapped reads stay zero
            end
        endcase
    end

    always_ff @(posedge clkin) begin
        if (rd_en) begin
            rdata <= rd_mux;    // held until next read
        end
    end

endmodule

`default_nettype wire

// File: logic/pll_out_divider.sv
/*
 * output clock enable dividers
 *  one counter per output, source is vco_tick or every cycle in bypass,
 *  ticks gated by en, clken and lock
 */
`timescale 1ns/10ps
`default_nettype none

module pll_out_divider (
    input  logic                        clkin,
    input  logic                        rst_n,
    input  pll_pkg::pll_cfg_t           cfg,
    input  logic                        cfg_chg,
    input  logic                        freqlock,
    input  logic                        vco_tick,
    output logic [pll_pkg::NOUT-1:0]    clkout_tick
);

    logic src;      // one source pulse this cycle

    // bypass passes the reference straight through
    assign src = cfg.bypass | vco_tick;

    // ============================================================
    // per-output counters
    // ============================================================
    for (genvar i = 0; i < pll_pkg::NOUT; i++) begin : g_out
        logic                        gate;
        logic                        wrap;
        logic [pll_pkg::DIVOUTW-1:0] cnt_q;

        assign gate = cfg.en & cfg.clken[i] & (cfg.bypass | freqlock);
        assign wrap = (cnt_q == cfg.divout[i] - 1'b1);     // divout-th pulse

        // comb tick so it drops the same cycle the gate does
        assign clkout_tick[i] = gate & src & wrap;

        always_ff @(posedge clkin or negedge rst_n) begin
            if (!rst_n) begin
                cnt_q <= '0;
            end else if (cfg_chg || !gate) begin
                cnt_q <= '0;                // realign on any change
            end else if (src) begin
                cnt_q <= wrap ? '0 : cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pll_lock_monitor.sv
/*
 * frequency lock monitor
 *  counts fb ticks per reference window of LOCK_WINDOW*divin cycles,
 *  freqlock after LOCK_COUNT good windows in a row, lost pulse on drop
 */
`timescale 1ns/10ps
`default_nettype none

module pll_lock_monitor (
    input  logic                  clkin,
    input  logic                  rst_n,
    input  pll_pkg::pll_cfg_t     cfg,
    input  logic                  cfg_chg,
    input  logic                  fb_tick,
    output logic                  freqlock,
    output logic                  lost_pulse
);

    logic [pll_pkg::WINW-1:0]    win_len;      // window length in clkin cycles
    logic [pll_pkg::WINW-1:0]    win_cnt_q;
    logic [pll_pkg::WINW-1:0]    fb_cnt_q;     // fb ticks so far this window
    logic [pll_pkg::WINW-1:0]    fb_total;     // including this cycle
    logic [pll_pkg::STREAKW-1:0] streak_q;     // good windows in a row
    logic                        win_end;
    logic                        win_good;

    // ============================================================
    // window arithmetic
    // ============================================================
    assign win_len  = pll_pkg::WINW'(pll_pkg::LOCK_WINDOW)
                    * pll_pkg::WINW'(cfg.divin);
    assign win_end  = (win_cnt_q == win_len - 1'b1);
    // at most one tick per cycle, so the count never passes win_len
    assign fb_total = fb_cnt_q + pll_pkg::WINW'(fb_tick);
    assign win_good = (fb_total >= pll_pkg::WINW'(pll_pkg::LOCK_WINDOW - pll_pkg::LOCK_TOL))
                   && (fb_total <= pll_pkg::WINW'(pll_pkg::LOCK_WINDOW + pll_pkg::LOCK_TOL));

    // ============================================================
    // counters and lock state
    // ============================================================
    always_ff @(posedge clkin or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt_q  <= '0;
            fb_cnt_q   <= '0;
            streak_q   <= '0;
            freqlock   <= 1'b0;
            lost_pulse <= 1'b0;
        end else begin
            lost_pulse <= 1'b0;

            if (cfg_chg || !cfg.en) begin
                // restart, idle while disabled
                win_cnt_q  <= '0;
                fb_cnt_q   <= '0;
                streak_q   <= '0;
                freqlock   <= 1'b0;
                lost_pulse <= freqlock;
            end else if (win_end) begin
                win_cnt_q <= '0;
                fb_cnt_q  <= '0;
                if (win_good) begin
                    if (streak_q != pll_pkg::STREAKW'(pll_pkg::LOCK_COUNT)) begin
                        streak_q <= streak_q + 1'b1;    // saturates at LOCK_COUNT
                    end
                    if (streak_q >= pll_pkg::STREAKW'(pll_pkg::LOCK_COUNT - 1)) begin
                        freqlock <= 1'b1;               // LOCK_COUNT-th good window
                    end
                end else begin
                    streak_q   <= '0;
                    freqlock   <= 1'b0;
                    lost_pulse <= freqlock;             // only if we were locked
                end
            end else begin
                win_cnt_q <= win_cnt_q + 1'b1;
                fb_cnt_q  <= fb_total;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pll_cfg_decode.sv
/*
 * register write decode
 *  configuration registers, zero-divider rejection,
 *  cfg change / error / status clear pulses
 */
`timescale 1ns/10ps
`default_nettype none

module pll_cfg_decode (
    input  logic                          clkin,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic [pll_pkg::ADDRW-1:0]     addr,
    input  logic [pll_pkg::DATAW-1:0]     wdata,
    output pll_pkg::pll_cfg_t             cfg,
    output logic                          cfg_chg,
    output logic                          err_pulse,
    output logic [2:0]                    clr_mask
);

    // write fields in register layout
    logic [pll_pkg::DIVINW-1:0]  wr_divin;
    logic [pll_pkg::DIVFBW-1:0]  wr_divfb;
    logic [pll_pkg::DIVOUTW-1:0] wr_divout;
    logic                        div_bad;
    logic                        divout_hit;
    logic [pll_pkg::OUTSELW-1:0] divout_sel;

    assign wr_divin   = wdata[pll_pkg::DIVINW-1:0];
    assign wr_divfb   = wdata[pll_pkg::DIVINW +: pll_pkg::DIVFBW];
    assign wr_divout  = wdata[pll_pkg::DIVOUTW-1:0];
    assign div_bad    = (wr_divin == '0) || (wr_divfb == '0);   // N or M of zero
    assign divout_hit = pll_pkg::is_divout(addr);
    assign divout_sel = pll_pkg::divout_idx(addr);

    // ============================================================
    // config registers and pulses
    // ============================================================
    always_ff @(posedge clkin or negedge rst_n) begin
        if (!rst_n) begin
            cfg       <= pll_pkg::CFG_RESET;
            cfg_chg   <= 1'b0;
            err_pulse <= 1'b0;
            clr_mask  <= '0;
        end else begin
            // strobes last one cycle
            cfg_chg   <= 1'b0;
            err_pulse <= 1'b0;
            clr_mask  <= '0;

            if (wr_en) begin
                case (addr)
                    pll_pkg::ADDR_CTRL: begin
                        cfg.en     <= wdata[0];
                        cfg.bypass <= wdata[1];
                        cfg_chg    <= 1'b1;
                    end
                    pll_pkg::ADDR_DIV: begin
                        if (div_bad) begin
                            err_pulse <= 1'b1;          // whole write dropped
                        end else begin
                            cfg.divin <= wr_divin;
                            cfg.divfb <= wr_divfb;
                            cfg_chg   <= 1'b1;
                        end
                    end
                    pll_pkg::ADDR_CLKEN: begin
                        cfg.clken <= wdata[pll_pkg::NOUT-1:0];
                        cfg_chg   <= 1'b1;
                    end
                    pll_pkg::ADDR_STATUS: begin
                        clr_mask <= wdata[2:0] & pll_pkg::STICKY_MASK;  // w1c
                    end
                    default: begin
                        if (divout_hit) begin
                            if (wr_divout == '0) begin
                                err_pulse <= 1'b1;      // zero output divide, same rule
                            end else begin
                                cfg.divout[divout_sel] <= wr_divout;
                                cfg_chg <= 1'b1;
                            end
                        end
                        // unmapped, nothing happens
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pll_pkg.sv
/*
 * shared definitions for the pll control block
 *  - widths, lock constants and register map
 *  - divout address helpers
 *  - configuration and status structs
 */
`default_nettype none

package pll_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int NOUT    = 4;             // output clocks
    localparam int DIVINW  = 8;             // reference divider
    localparam int DIVFBW  = 16;            // feedback divider
    localparam int DIVOUTW = 8;             // per-output divider
    localparam int ADDRW   = 4;
    localparam int DATAW   = 32;
    localparam int OUTSELW = $clog2(NOUT);  // divout register index

    // ============================================================
    // lock detection
    // ============================================================
    localparam int LOCK_WINDOW = 8;     // fb ticks expected per window
    localparam int LOCK_TOL    = 1;     // +/- slack on that count
    localparam int LOCK_COUNT  = 3;     // good windows in a row for lock
    localparam int WINW    = DIVINW + $clog2(LOCK_WINDOW);  // window length / fb count
    localparam int STREAKW = $clog2(LOCK_COUNT + 1);

    // ============================================================
    // register map
    // ============================================================
    localparam logic [ADDRW-1:0] ADDR_CTRL    = 4'd0;   // bit0 en, bit1 bypass
    localparam logic [ADDRW-1:0] ADDR_DIV     = 4'd1;   // divfb, divin
    localparam logic [ADDRW-1:0] ADDR_CLKEN   = 4'd2;
    localparam logic [ADDRW-1:0] ADDR_DIVOUT0 = 4'd3;   // one word per output
    localparam logic [ADDRW-1:0] ADDR_STATUS  = 4'd15;  // w1c on sticky bits

    // status bit positions, same order as pll_stat_t
    localparam int STAT_ERR  = 0;
    localparam int STAT_LOST = 1;
    localparam int STAT_LOCK = 2;
    localparam logic [2:0] STICKY_MASK = 3'b011;  // freqlock itself is live

    // divout window is ADDR_DIVOUT0 .. ADDR_DIVOUT0+NOUT-1
    function automatic logic is_divout(input logic [ADDRW-1:0] a);
        return (a >= ADDR_DIVOUT0) && (int'(a) < int'(ADDR_DIVOUT0) + NOUT);
    endfunction

    function automatic logic [OUTSELW-1:0] divout_idx(input logic [ADDRW-1:0] a);
        return OUTSELW'(a - ADDR_DIVOUT0);
    endfunction

    // ============================================================
    // structs
    // ============================================================
    typedef struct packed {
        logic                             en;
        logic                             bypass;
        logic [DIVINW-1:0]                divin;
        logic [DIVFBW-1:0]                divfb;
        logic [NOUT-1:0]                  clken;
        logic [NOUT-1:0][DIVOUTW-1:0]     divout;
    } pll_cfg_t;

    typedef struct packed {
        logic freqlock;
        logic lock_lost;    // sticky
        logic cfg_err;      // sticky
    } pll_stat_t;

    localparam pll_cfg_t CFG_RESET = '{
        en:     1'b0,
        bypass: 1'b0,
        divin:  DIVINW'(1),
        divfb:  DIVFBW'(1),
        clken:  '0,
        divout: {NOUT{DIVOUTW'(1)}}
    };

endpackage

`default_nettype wire
